// ==== Makefile ====
# Verilator lint and simulation of the eforth core
TOP = tb_eforth

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module eforth_top
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== eforth_exec.sv ====
`timescale 1ns/1ps
/* execute stage, one opcode per cycle except AT which takes two
   both stacks must hold enough cells for each op, underflow is not trapped here */
module eforth_exec (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic                   f_valid,
    input  eforth_pkg::code_word_u f_word,
    input  logic                   f_lit,
    output logic                   hold,      // AT waiting on memory
    output logic                   redirect,
    output eforth_pkg::addr_t      target,
    stack_if.ctl                   ds,
    stack_if.ctl                   rs,
    output eforth_pkg::addr_t      d_addr,
    output logic                   d_we,
    output eforth_pkg::cell_t      d_wdata,
    input  eforth_pkg::cell_t      d_rdata,
    output logic                   clr,       // empties both stacks
    output logic                   bsy
);
    import eforth_pkg::*;

    opcode_e op;
    cell_t   t;         // data top
    cell_t   n;         // data next
    cell_t   r;         // return top
    logic    ex;        // a word is here and the run is live
    logic    bye;
    logic    done;      // BYE seen, wait for en to drop
    logic    at_ph;     // second cycle of AT

    assign op      = f_word.ins.op;
    assign t       = ds.top;
    assign n       = ds.nxt;
    assign r       = rs.top;
    assign ex      = bsy && f_valid;
    assign target  = f_word.ins.arg[ASZ-1:0];
    assign d_addr  = t[ASZ-1:0];    // AT and STOR both address by top
    assign d_wdata = n;
    assign clr     = !en;

    always_comb begin
        ds.push  = 1'b0;
        ds.pop   = 1'b0;
        ds.load  = 1'b0;
        ds.din   = '0;
        rs.push  = 1'b0;
        rs.pop   = 1'b0;
        rs.load  = 1'b0;
        rs.din   = '0;
        redirect = 1'b0;
        hold     = 1'b0;
        d_we     = 1'b0;
        bye      = 1'b0;
        if (ex && f_lit) begin
            ds.push = 1'b1;                 // literal cell
            ds.din  = f_word.lit;
        end else if (ex) begin
            case (op)
                op_nop, op_dolit: ;         // DOLIT work done by fetch tag
                op_bran:  redirect = 1'b1;
                op_zbran: begin
                    ds.pop   = 1'b1;
                    redirect = (t == '0);
                end
                op_donext: begin
                    if (r != '0) begin
                        rs.load  = 1'b1;    // count down, loop again
                        rs.din   = r - 1'b1;
                        redirect = 1'b1;
                    end else begin
                        rs.pop = 1'b1;      // loop finished
                    end
                end
                op_tor: begin
                    ds.pop  = 1'b1;
                    rs.push = 1'b1;
                    rs.din  = t;
                end
                op_rfrom: begin
                    rs.pop  = 1'b1;
                    ds.push = 1'b1;
                    ds.din  = r;
                end
                op_rat: begin
                    ds.push = 1'b1;
                    ds.din  = r;
                end
                op_dup: begin
                    ds.push = 1'b1;
                    ds.din  = t;
                end
                op_drop: ds.pop = 1'b1;
                op_over: begin
                    ds.push = 1'b1;
                    ds.din  = n;
                end
                op_swap: begin
                    ds.push = 1'b1;         // push+load swaps
                    ds.load = 1'b1;
                    ds.din  = n;
                end
                op_add, op_sub, op_and, op_or, op_xor, op_eq, op_lt: begin
                    ds.pop  = 1'b1;         // two in, one out
                    ds.load = 1'b1;
                    case (op)
                        op_add:  ds.din = n + t;    // wraps
                        op_sub:  ds.din = n - t;
                        op_and:  ds.din = n & t;
                        op_or:   ds.din = n | t;
                        op_xor:  ds.din = n ^ t;
                        op_eq:   ds.din = {DSZ{n == t}};
                        default: ds.din = {DSZ{$signed(n) < $signed(t)}};
                    endcase
                end
                op_neg: begin
                    ds.load = 1'b1;
                    ds.din  = -t;
                end
                op_zeq: begin
                    ds.load = 1'b1;
                    ds.din  = {DSZ{t == '0}};
                end
                op_zlt: begin
                    ds.load = 1'b1;
                    ds.din  = {DSZ{t[DSZ-1]}};  // sign bit
                end
                op_at: begin
                    if (!at_ph) begin
                        hold = 1'b1;        // RAM read under way
                    end else begin
                        ds.load = 1'b1;
                        ds.din  = d_rdata;
                    end
                end
                op_stor: begin
                    d_we    = 1'b1;
                    ds.push = 1'b1;         // all three drops two
                    ds.pop  = 1'b1;
                    ds.load = 1'b1;
                end
                op_bye:  bye = 1'b1;
                default: ;
            endcase
        end
    end

    // run control
    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            bsy   <= 1'b0;
            done  <= 1'b0;
            at_ph <= 1'b0;
        end else begin
            at_ph <= hold;                  // high for AT second cycle only
            if (bye) begin
                bsy  <= 1'b0;
                done <= 1'b1;
            end else if (!done) begin
                bsy  <= 1'b1;               // one edge after en
            end
        end
    end

    // fetch must only hand over encoded opcodes while running
    a_known_op: assert property (@(posedge clk) disable iff (!rst_n)
        (ex && !f_lit) |-> (f_word.ins.op <= op_bye));

endmodule

// ==== eforth_fetch.sv ====
`timescale 1ns/1ps
/* fetch stage, one read in flight and one word handed to execute
   the cell after a DOLIT is tagged as literal here, execute does not look at it again */
module eforth_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  eforth_pkg::addr_t      pfa,       // first code cell
    input  logic                   hold,      // freeze ip and word
    input  logic                   redirect,  // taken branch, one cycle
    input  eforth_pkg::addr_t      target,
    output eforth_pkg::addr_t      i_addr,
    input  eforth_pkg::cell_t      i_data,
    output logic                   f_valid,
    output eforth_pkg::code_word_u f_word,
    output logic                   f_lit,
    output eforth_pkg::addr_t      f_pc
);
    import eforth_pkg::*;

    addr_t ip;          // next cell to read
    addr_t rd_pc;       // cell now in the RAM read
    logic  rd_v;        // that read is wanted
    logic  prev_dolit;  // word in execute is a real DOLIT

    // under hold the same cell is read again so the in-flight word survives
    assign i_addr = hold ? rd_pc : ip;

    assign prev_dolit = f_valid && !f_lit && (f_word.ins.op == op_dolit);

    always_ff @(posedge clk) begin
        if (!rst_n || !en) begin
            ip      <= pfa;
            rd_v    <= 1'b0;
            f_valid <= 1'b0;
            f_lit   <= 1'b0;
        end else if (redirect) begin
            ip      <= target;
            rd_v    <= 1'b0;    // squash the read in flight
            f_valid <= 1'b0;
            f_lit   <= 1'b0;
        end else if (!hold) begin
            ip      <= ip + 1'b1;
            rd_v    <= 1'b1;
            f_valid <= rd_v;
            f_lit   <= rd_v && prev_dolit;
        end
    end

    // word and its address, no reset needed behind f_valid
    always_ff @(posedge clk) begin
        if (!hold) begin
            rd_pc      <= i_addr;
            f_word.lit <= i_data;
            f_pc       <= rd_pc;
        end
    end

endmodule

// ==== eforth_if.sv ====
`timescale 1ns/1ps
/* control and view of one LIFO, shared by data and return stack
   commands act at the next edge, combinations outside the list below are not used */
interface stack_if;
    import eforth_pkg::*;

    // push pop load
    //  1    0    0   push din
    //  0    1    0   drop top
    //  1    1    0   replace top with din
    //  0    0    1   write top with din
    //  0    1    1   drop top, din into new top (binary ops)
    //  1    0    1   din into top, old top under it (swap)
    //  1    1    1   drop two
    logic           push;
    logic           pop;
    logic           load;
    cell_t          din;
    cell_t          top;    // valid when depth > 0
    cell_t          nxt;    // valid when depth > 1
    logic [SPW-1:0] depth;

    modport ctl (
        output push, pop, load, din,
        input  top, nxt, depth
    );

    modport mem (
        input  push, pop, load, din,
        output top, nxt, depth
    );

endinterface

// ==== eforth_mem.sv ====
`timescale 1ns/1ps
/* 1K-cell code and data RAM, both reads registered, old data on read during write
   load port shares the data write path, only used while the core is stopped */
module eforth_mem (
    input  logic              clk,
    input  eforth_pkg::addr_t i_addr,     // fetch read
    output eforth_pkg::cell_t i_data,
    input  eforth_pkg::addr_t d_addr,     // exec data port
    input  logic              d_we,
    input  eforth_pkg::cell_t d_wdata,
    output eforth_pkg::cell_t d_rdata,
    input  logic              load_we,    // program load
    input  eforth_pkg::addr_t load_addr,
    input  eforth_pkg::cell_t load_data
);
    import eforth_pkg::*;

    cell_t ram [2**ASZ];
    logic  w_en;
    addr_t w_addr;
    cell_t w_data;

    // load wins the write port
    assign w_en   = load_we | d_we;
    assign w_addr = load_we ? load_addr : d_addr;
    assign w_data = load_we ? load_data : d_wdata;

    always_ff @(posedge clk) begin
        if (w_en) begin
            ram[w_addr] <= w_data;
        end
        i_data  <= ram[i_addr];     // word back next cycle
        d_rdata <= ram[d_addr];
    end

    // loading while a program stores means the tb raised en too early
    a_load_idle: assert property (@(posedge clk) load_we |-> !d_we);

endmodule

// ==== eforth_pkg.sv ====
/* sizes, opcodes and code word layout for the eforth core
   a code cell is an 8-bit opcode over a 24-bit arg, only the low ASZ bits of arg are a target
   a cell after a DOLIT is read as a 32-bit literal whatever its top byte holds */
package eforth_pkg;

    localparam int DSZ      = 32;   // cell width
    localparam int ASZ      = 10;   // 1K cells, code and data share them
    localparam int SS_DEPTH = 16;   // entries per stack
    localparam int SPW      = 5;    // depth count, 0..16

    typedef logic [DSZ-1:0] cell_t;
    typedef logic [ASZ-1:0] addr_t;

    // flow ops first, same order as the full eforth set
    typedef enum logic [7:0] {
        op_nop    = 8'd0,
        op_dolit  = 8'd1,   // next cell is a literal
        op_bran   = 8'd2,
        op_zbran  = 8'd3,   // 0BRAN
        op_donext = 8'd4,
        op_tor    = 8'd5,
        op_rfrom  = 8'd6,
        op_rat    = 8'd7,
        // stack ops
        op_dup    = 8'd8,
        op_drop   = 8'd9,
        op_over   = 8'd10,
        op_swap   = 8'd11,
        // alu
        op_add    = 8'd12,
        op_sub    = 8'd13,
        op_and    = 8'd14,
        op_or     = 8'd15,
        op_xor    = 8'd16,
        op_neg    = 8'd17,
        // compare, true is all ones
        op_zeq    = 8'd18,
        op_zlt    = 8'd19,
        op_eq     = 8'd20,
        op_lt     = 8'd21,
        // memory
        op_at     = 8'd22,  // two cycles
        op_stor   = 8'd23,
        op_bye    = 8'd24   // keep last, checked as upper bound
    } opcode_e;

    // one cell, two readings
    typedef union packed {
        struct packed {
            opcode_e     op;
            logic [23:0] arg;   // branch target in low ASZ bits
        } ins;
        cell_t lit;             // literal cell after DOLIT
    } code_word_u;

endpackage

// ==== eforth_stack.sv ====
`timescale 1ns/1ps
/* register LIFO of SS_DEPTH cells, top and next shown without delay
   overflow and underflow wrap the slot index, the caller must avoid them */
module eforth_stack (
    input  logic clk,
    input  logic rst_n,
    input  logic clr,       // empty at next edge
    stack_if.mem s
);
    import eforth_pkg::*;

    cell_t          mem [SS_DEPTH];
    logic [SPW-1:0] sp;     // entries held
    logic [SPW-2:0] fi;     // first free slot
    logic [SPW-2:0] ti;     // top slot
    logic [SPW-2:0] ni;     // slot under top

    assign fi = sp[SPW-2:0];
    assign ti = fi - 1'b1;
    assign ni = fi - 2'd2;

    assign s.top   = mem[ti];
    assign s.nxt   = mem[ni];
    assign s.depth = sp;

    // depth count
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            sp <= '0;
        end else begin
            case ({s.push, s.pop, s.load})
                3'b100:  sp <= sp + 1'b1;
                3'b010:  sp <= sp - 1'b1;
                3'b011:  sp <= sp - 1'b1;   // binary op result
                3'b111:  sp <= sp - 2'd2;
                default: ;                  // replace, write, swap keep depth
            endcase
        end
    end

    // cells
    always_ff @(posedge clk) begin
        case ({s.push, s.pop, s.load})
            3'b100:  mem[fi] <= s.din;
            3'b110:  mem[ti] <= s.din;
            3'b001:  mem[ti] <= s.din;
            3'b011:  mem[ni] <= s.din;      // lands on the new top
            3'b101: begin
                mem[ti] <= s.din;
                mem[ni] <= s.top;           // old top sinks one place
            end
            default: ;
        endcase
    end

    // exec must never take more than is there
    // load with push or pop touches the two top cells
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n || clr)
        (s.pop || s.load) |-> s.depth >= ((s.load && (s.push || s.pop)) ? 2 : 1));

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n || clr)
        (s.push && !s.pop && !s.load) |-> s.depth < SS_DEPTH);

endmodule

// ==== eforth_top.sv ====
`timescale 1ns/1ps
/* eforth inner interpreter, fetch then execute over one shared RAM
   load the program only while en is low, results hold once bsy falls */
module eforth_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,        // start and hold a run
    input  eforth_pkg::addr_t          pfa,
    input  logic                       load_we,
    input  eforth_pkg::addr_t          load_addr,
    input  eforth_pkg::cell_t          load_data,
    output logic                       bsy,
    output eforth_pkg::cell_t          tos,
    output logic [eforth_pkg::SPW-1:0] ds_depth
);
    import eforth_pkg::*;

    addr_t      i_addr;
    cell_t      i_data;
    logic       f_valid;
    code_word_u f_word;
    logic       f_lit;
    logic       hold;
    logic       redirect;
    addr_t      target;
    addr_t      d_addr;
    logic       d_we;
    cell_t      d_wdata;
    cell_t      d_rdata;
    logic       clr;

    stack_if ds ();         // data stack
    stack_if rs ();         // return stack

    eforth_fetch i_fetch (
        .clk(clk), .rst_n(rst_n), .en(en), .pfa(pfa),
        .hold(hold), .redirect(redirect), .target(target),
        .i_addr(i_addr), .i_data(i_data),
        .f_valid(f_valid), .f_word(f_word), .f_lit(f_lit), .f_pc()
    );

    eforth_exec i_exec (
        .clk(clk), .rst_n(rst_n), .en(en),
        .f_valid(f_valid), .f_word(f_word), .f_lit(f_lit),
        .hold(hold), .redirect(redirect), .target(target),
        .ds(ds), .rs(rs),
        .d_addr(d_addr), .d_we(d_we), .d_wdata(d_wdata), .d_rdata(d_rdata),
        .clr(clr), .bsy(bsy)
    );

    eforth_mem i_mem (
        .clk(clk), .i_addr(i_addr), .i_data(i_data),
        .d_addr(d_addr), .d_we(d_we), .d_wdata(d_wdata), .d_rdata(d_rdata),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data)
    );

    eforth_stack i_ds (.clk(clk), .rst_n(rst_n), .clr(clr), .s(ds));
    eforth_stack i_rs (.clk(clk), .rst_n(rst_n), .clr(clr), .s(rs));

    assign tos      = ds.top;
    assign ds_depth = ds.depth;

endmodule

// ==== flist.f ====
eforth_pkg.sv
eforth_if.sv
eforth_stack.sv
eforth_mem.sv
eforth_fetch.sv
eforth_exec.sv
eforth_top.sv
tb_eforth.sv

// ==== tb_eforth.sv ====
`timescale 1ns/1ps
/* testbench for eforth_top, programs come from a table, the table runs twice
   all cells start random, each program sits at its own pfa, data cell at 0x300 */
module tb_eforth;
    import eforth_pkg::*;

    localparam int    NROWS = 8;
    localparam int    MAXC  = 16;       // cells per program
    localparam int    LIMIT = 400;      // cycles per wait
    localparam addr_t DADDR = 10'h300;  // STOR/AT cell, clear of all programs

    logic           clk;
    logic           rst_n;
    logic           en;
    addr_t          pfa;
    logic           load_we;
    addr_t          load_addr;
    cell_t          load_data;
    logic           bsy;
    cell_t          tos;
    logic [SPW-1:0] ds_depth;

    // program table with expected results
    cell_t          prog [NROWS][MAXC];
    int             row_len [NROWS];
    addr_t          row_pfa [NROWS];
    cell_t          exp_tos [NROWS];
    logic [SPW-1:0] exp_depth [NROWS];
    int             nr;         // row being built
    int             mism;       // wrong values
    int             other;      // timeouts
    bit             ok;         // last wait finished in time

    eforth_top i_dut (
        .clk(clk), .rst_n(rst_n), .en(en), .pfa(pfa),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .bsy(bsy), .tos(tos), .ds_depth(ds_depth)
    );

    always #10 clk = ~clk;      // 20 ns period

    // opcode in the top byte, target in the low bits of arg
    function automatic cell_t code(opcode_e o, addr_t arg);
        code_word_u w;
        w.ins.op  = o;
        w.ins.arg = 24'(arg);
        return w.lit;
    endfunction

    task automatic begin_row();
        row_pfa[nr] = addr_t'(32 * (nr + 1));
        row_len[nr] = 0;
    endtask

    task automatic put(cell_t c);
        prog[nr][row_len[nr]] = c;
        row_len[nr] = row_len[nr] + 1;
    endtask

    task automatic put_op(opcode_e o);
        put(code(o, '0));
    endtask

    task automatic put_lit(cell_t v);
        put(code(op_dolit, '0));
        put(v);
    endtask

    // off counts cells from the row's pfa
    task automatic put_br(opcode_e o, int off);
        put(code(o, row_pfa[nr] + addr_t'(off)));
    endtask

    task automatic end_row(cell_t t, logic [SPW-1:0] d);
        exp_tos[nr]   = t;
        exp_depth[nr] = d;
        nr = nr + 1;
    endtask

    task automatic build_table();
        begin_row();    // add, sub wrapping below zero, neg
        put_lit(32'd5);
        put_lit(32'd7);
        put_op(op_add);
        put_lit(32'h14);
        put_op(op_sub);
        put_op(op_neg);
        put_op(op_bye);
        end_row(32'd8, 5'd1);
        begin_row();    // add wraps past 2^32, then and/or/xor
        put_lit(32'hFFFF_FFF0);
        put_lit(32'h20);
        put_op(op_add);
        put_lit(32'hFF);
        put_op(op_and);
        put_lit(32'h0F);
        put_op(op_or);
        put_lit(32'h3);
        put_op(op_xor);
        put_op(op_bye);
        end_row(32'h1C, 5'd1);
        begin_row();    // 1 2 -> 1 2 1 -> 1 1 2 -> 1 1 2 2 -> 1 1 2 -> 1 2 1 -> 1 2 1 2 -> 1 2 3
        put_lit(32'd1);
        put_lit(32'd2);
        put_op(op_over);
        put_op(op_swap);
        put_op(op_dup);
        put_op(op_drop);
        put_op(op_swap);
        put_op(op_over);
        put_op(op_add);
        put_op(op_bye);
        end_row(32'd3, 5'd3);
        begin_row();    // signed 7 < -1 is false so zeq of it and zlt of -3 both give true
        put_lit(32'd7);
        put_lit(32'hFFFF_FFFF);
        put_op(op_lt);
        put_op(op_zeq);
        put_lit(32'hFFFF_FFFD);
        put_op(op_zlt);
        put_op(op_eq);      // true eq true
        put_op(op_bye);
        end_row(32'hFFFF_FFFF, 5'd1);
        begin_row();    // 0bran falls through on 1, taken on 0, bran skips a literal
        put_lit(32'd1);
        put_br(op_zbran, 13);       // wrong path ends with empty stack
        put_lit(32'd0);
        put_br(op_zbran, 8);
        put_lit(32'h111);
        put_br(op_bran, 11);
        put_lit(32'h222);
        put_lit(32'h333);
        put_op(op_bye);
        end_row(32'h333, 5'd1);
        begin_row();    // 0x100 + r@ + r> = 0x1AA
        put_lit(32'h55);
        put_op(op_tor);
        put_lit(32'h100);
        put_op(op_rat);
        put_op(op_add);
        put_op(op_rfrom);
        put_op(op_add);
        put_op(op_bye);
        end_row(32'h1AA, 5'd1);
        begin_row();    // count 3, body runs 4 times, 4 * 5
        put_lit(32'd0);
        put_lit(32'd3);
        put_op(op_tor);
        put_lit(32'd5);
        put_op(op_add);
        put_br(op_donext, 5);
        put_op(op_bye);
        end_row(32'h14, 5'd1);
        begin_row();    // store then fetch back, plus one
        put_lit(32'hCAFE_1234);
        put_lit(cell_t'(DADDR));
        put_op(op_stor);
        put_lit(cell_t'(DADDR));
        put_op(op_at);
        put_lit(32'd1);
        put_op(op_add);
        put_op(op_bye);
        end_row(32'hCAFE_1235, 5'd1);
    endtask

    task automatic check_cell(string name, cell_t got, cell_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mism++;
        end
    endtask

    task automatic check_depth(string name, logic [SPW-1:0] got, logic [SPW-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mism++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            mism++;
        end
    endtask

    // one cell per cycle that lands on the next rising edge
    task automatic write_cell(addr_t a, cell_t d);
        @(negedge clk);
        load_we   = 1'b1;
        load_addr = a;
        load_data = d;
    endtask

    task automatic load_program(int r);
        @(negedge clk);
        pfa = row_pfa[r];
        for (int i = 0; i < row_len[r]; i++) begin
            write_cell(row_pfa[r] + addr_t'(i), prog[r][i]);
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic wait_bsy(logic level, int r);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < LIMIT) begin
            @(negedge clk);
            ok = (bsy === level);
            n++;
        end
        if (!ok) begin
            $display("timeout: bsy never went to %0d while running row %0d", level, r);
            other++;
        end
    endtask

    initial begin
        bit stop;
        clk       = 1'b0;
        rst_n     = 1'b0;
        en        = 1'b0;
        pfa       = '0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        mism      = 0;
        other     = 0;
        nr        = 0;
        stop      = 1'b0;
        void'($urandom(32'h3866_936f));
        build_table();

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("bsy after reset", bsy, 1'b0);
        check_depth("ds_depth after reset", ds_depth, '0);

        for (int a = 0; a < 2**ASZ; a++) begin
            write_cell(addr_t'(a), $urandom);    // junk outside the programs
        end
        @(negedge clk);
        load_we = 1'b0;

        // second pass repeats every row so stale stacks would show here
        for (int p = 0; p < 2 && !stop; p++) begin
            for (int r = 0; r < NROWS && !stop; r++) begin
                load_program(r);
                @(negedge clk);
                en = 1'b1;
                wait_bsy(1'b1, r);
                if (ok) begin
                    wait_bsy(1'b0, r);
                end
                if (!ok) begin
                    stop = 1'b1;
                end else begin
                    check_cell($sformatf("tos row %0d pass %0d", r, p), tos, exp_tos[r]);
                    check_depth($sformatf("ds_depth row %0d pass %0d", r, p),
                                ds_depth, exp_depth[r]);
                    @(negedge clk);
                    en = 1'b0;
                    @(negedge clk);         // clr has acted by now
                    check_flag($sformatf("bsy idle row %0d", r), bsy, 1'b0);
                    check_depth($sformatf("ds_depth idle row %0d", r), ds_depth, '0);
                end
            end
        end

        $display("errors: %0d mismatch, %0d other", mism, other);
        if (mism == 0 && other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
